/* common/uart_pkg.sv */
// Serial line framing constants
`default_nettype none

package uart_pkg;

  localparam int DATA_BITS = 8;

  // Low samples in a row that count as a break
  localparam int BREAK_THRESHOLD = 10;

  localparam int BIT_COUNT_W = $clog2(DATA_BITS);
  localparam int BREAK_COUNT_W = $clog2(BREAK_THRESHOLD + 1);

  // Receiver state codes
  localparam logic [2:0] RX_IDLE  = 3'b000;
  localparam logic [2:0] RX_START = 3'b001;
  localparam logic [2:0] RX_DATA  = 3'b011;
  localparam logic [2:0] RX_STOP  = 3'b010;
  localparam logic [2:0] RX_BREAK = 3'b110;
  localparam logic [2:0] RX_WAIT  = 3'b100;

  typedef logic [DATA_BITS-1:0] uart_char_t;

endpackage

`default_nettype wire

/* common/cmd_pkg.sv */
// Register command definitions
`default_nettype none

package cmd_pkg;

  localparam int NUM_REGS = 8;

  typedef enum logic [1:0] {
    CMD_READ  = 2'd0,
    CMD_WRITE = 2'd1,
    CMD_ADD   = 2'd2,
    CMD_CLEAR = 2'd3
  } cmd_op_t;

  typedef logic [2:0] cmd_index_t;

  // Echoed back with the response
  typedef logic [2:0] cmd_tag_t;

  // First byte of every command
  typedef struct packed {
    cmd_op_t    op;
    cmd_index_t index;
    cmd_tag_t   tag;
  } cmd_header_t;

  // Same byte seen as header or as operand
  typedef union packed {
    cmd_header_t hdr;
    logic [7:0]  operand;
  } cmd_byte_u;

endpackage

`default_nettype wire

/* verilog/uart_rx/uart_break_detect.sv */
// Line receiver with break detection
`timescale 1ns/1ps
`default_nettype none

module uart_break_detect (
  input  logic                clock,
  input  logic                reset_n,
  input  logic                rx_in,
  output uart_pkg::uart_char_t rx_data,
  output logic                rx_valid,
  input  logic                rx_ready,
  output logic                break_detect
);
  import uart_pkg::*;

  logic                     rx_q;
  logic [2:0]               state;
  logic [2:0]               next_state;
  logic [BIT_COUNT_W-1:0]   bit_count;
  logic [BIT_COUNT_W-1:0]   next_bit_count;
  logic [BREAK_COUNT_W-1:0] low_run;
  logic [BREAK_COUNT_W-1:0] low_run_inc;
  logic [BREAK_COUNT_W-1:0] next_low_run;
  uart_char_t               shift_reg;
  uart_char_t               next_shift_reg;

  // Saturates at the threshold
  assign low_run_inc = (low_run == BREAK_COUNT_W'(BREAK_THRESHOLD)) ?
                       low_run : low_run + 1'b1;

  always_comb begin
    next_state     = state;
    next_bit_count = bit_count;
    next_shift_reg = shift_reg;
    next_low_run   = rx_q ? '0 : low_run_inc;

    case (state)
      RX_IDLE: begin
        if (!rx_q) begin
          next_state = RX_START;
        end
      end

      // First data bit follows the start sample directly
      RX_START: begin
        next_shift_reg = {rx_q, shift_reg[DATA_BITS-1:1]};
        next_bit_count = BIT_COUNT_W'(1);
        next_state     = RX_DATA;
      end

      RX_DATA: begin
        next_shift_reg = {rx_q, shift_reg[DATA_BITS-1:1]};
        if (bit_count == BIT_COUNT_W'(DATA_BITS - 1)) begin
          next_state = RX_STOP;
        end else begin
          next_bit_count = bit_count + 1'b1;
        end
      end

      RX_STOP: begin
        if (rx_q) begin
          next_state = RX_WAIT;
        end else if (low_run_inc >= BREAK_COUNT_W'(BREAK_THRESHOLD)) begin
          next_state = RX_BREAK;
        end else begin
          // Framing error, character dropped
          next_state = RX_IDLE;
        end
      end

      RX_WAIT: begin
        next_low_run = '0;
        if (rx_ready) begin
          next_state = RX_IDLE;
        end
      end

      RX_BREAK: begin
        if (rx_q) begin
          next_state = RX_IDLE;
        end
      end

      default: next_state = RX_IDLE;
    endcase
  end

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      rx_q         <= 1'b1;
      state        <= RX_IDLE;
      bit_count    <= '0;
      low_run      <= '0;
      break_detect <= 1'b0;
    end else begin
      rx_q      <= rx_in;
      state     <= next_state;
      bit_count <= next_bit_count;
      low_run   <= next_low_run;

      if (state == RX_BREAK) begin
        break_detect <= 1'b1;
      end else if (state == RX_IDLE) begin
        break_detect <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    shift_reg <= next_shift_reg;
  end

  // Character held in the shift register until taken
  assign rx_valid = (state == RX_WAIT);
  assign rx_data  = shift_reg;

endmodule

`default_nettype wire

/* verilog/cmd_decode.sv */
// Command byte decoder
`timescale 1ns/1ps
`default_nettype none

module cmd_decode (
  input  logic                 clock,
  input  logic                 reset_n,
  input  uart_pkg::uart_char_t rx_data,
  input  logic                 rx_valid,
  output logic                 rx_ready,
  input  logic                 break_detect,
  input  logic                 busy,
  input  logic                 result_strobe,
  output logic                 exec_start,
  output cmd_pkg::cmd_op_t     exec_op,
  output cmd_pkg::cmd_index_t  exec_index,
  output cmd_pkg::cmd_tag_t    exec_tag,
  output uart_pkg::uart_char_t exec_operand
);
  import cmd_pkg::*;

  cmd_byte_u   rx_byte;
  cmd_header_t hdr_q;
  logic        operand_phase;
  logic        in_flight;
  logic        accept;
  logic        needs_operand;
  logic        issue;

  assign rx_byte  = rx_data;
  assign rx_ready = !busy && !in_flight;
  assign accept   = rx_valid && rx_ready;

  assign needs_operand = (rx_byte.hdr.op == CMD_WRITE) || (rx_byte.hdr.op == CMD_ADD);

  // Last byte of a command
  assign issue = accept && !break_detect && (operand_phase || !needs_operand);

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      operand_phase <= 1'b0;
      in_flight     <= 1'b0;
      exec_start    <= 1'b0;
    end else begin
      exec_start <= issue;

      if (break_detect) begin
        operand_phase <= 1'b0;
      end else if (accept) begin
        operand_phase <= !operand_phase && needs_operand;
      end

      // One command in the back end at a time
      if (issue) begin
        in_flight <= 1'b1;
      end else if (result_strobe) begin
        in_flight <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (accept && !operand_phase) begin
      hdr_q <= rx_byte.hdr;
    end

    if (issue) begin
      if (operand_phase) begin
        exec_op      <= hdr_q.op;
        exec_index   <= hdr_q.index;
        exec_tag     <= hdr_q.tag;
        exec_operand <= rx_byte.operand;
      end else begin
        exec_op      <= rx_byte.hdr.op;
        exec_index   <= rx_byte.hdr.index;
        exec_tag     <= rx_byte.hdr.tag;
        exec_operand <= '0;
      end
    end
  end

endmodule

`default_nettype wire

/* verilog/cmd_execute.sv */
// Register file and command execution
`timescale 1ns/1ps
`default_nettype none

module cmd_execute (
  input  logic                 clock,
  input  logic                 reset_n,
  input  logic                 exec_start,
  input  cmd_pkg::cmd_op_t     exec_op,
  input  cmd_pkg::cmd_index_t  exec_index,
  input  cmd_pkg::cmd_tag_t    exec_tag,
  input  uart_pkg::uart_char_t exec_operand,
  output logic                 result_strobe,
  output uart_pkg::uart_char_t result_value,
  output cmd_pkg::cmd_tag_t    result_tag
);
  import cmd_pkg::*;
  import uart_pkg::*;

  uart_char_t regs [NUM_REGS];
  uart_char_t cur_value;
  uart_char_t new_value;

  assign cur_value = regs[exec_index];

  always_comb begin
    case (exec_op)
      CMD_READ:  new_value = cur_value;
      CMD_WRITE: new_value = exec_operand;
      // Wraps at 256
      CMD_ADD:   new_value = cur_value + exec_operand;
      CMD_CLEAR: new_value = '0;
      default:   new_value = cur_value;
    endcase
  end

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
      result_strobe <= 1'b0;
    end else begin
      result_strobe <= exec_start;
      if (exec_start && exec_op != CMD_READ) begin
        regs[exec_index] <= new_value;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (exec_start) begin
      result_value <= new_value;
      result_tag   <= exec_tag;
    end
  end

endmodule

`default_nettype wire

/* verilog/cmd_result.sv */
// Response holding stage
`timescale 1ns/1ps
`default_nettype none

module cmd_result (
  input  logic                 clock,
  input  logic                 reset_n,
  input  logic                 result_strobe,
  input  uart_pkg::uart_char_t result_value,
  input  cmd_pkg::cmd_tag_t    result_tag,
  output logic                 busy,
  output uart_pkg::uart_char_t resp_data,
  output cmd_pkg::cmd_tag_t    resp_tag,
  output logic                 resp_valid,
  input  logic                 resp_ready
);

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      resp_valid <= 1'b0;
    end else if (result_strobe) begin
      resp_valid <= 1'b1;
    end else if (resp_valid && resp_ready) begin
      resp_valid <= 1'b0;
    end
  end

  // Upstream never sends a result while one is held
  always_ff @(posedge clock) begin
    if (result_strobe) begin
      resp_data <= result_value;
      resp_tag  <= result_tag;
    end
  end

  assign busy = resp_valid;

endmodule

`default_nettype wire

/* verilog/uart_cmd_port.sv */
// Serial register access port
`timescale 1ns/1ps
`default_nettype none

module uart_cmd_port (
  input  logic                 clock,
  input  logic                 reset_n,
  input  logic                 rx_in,
  output uart_pkg::uart_char_t resp_data,
  output cmd_pkg::cmd_tag_t    resp_tag,
  output logic                 resp_valid,
  input  logic                 resp_ready,
  output logic                 break_detect
);
  import cmd_pkg::*;
  import uart_pkg::*;

  uart_char_t rx_data;
  logic       rx_valid;
  logic       rx_ready;
  logic       busy;
  logic       exec_start;
  cmd_op_t    exec_op;
  cmd_index_t exec_index;
  cmd_tag_t   exec_tag;
  uart_char_t exec_operand;
  logic       result_strobe;
  uart_char_t result_value;
  cmd_tag_t   result_tag;

  uart_break_detect rx0 (
    .clock        (clock),
    .reset_n      (reset_n),
    .rx_in        (rx_in),
    .rx_data      (rx_data),
    .rx_valid     (rx_valid),
    .rx_ready     (rx_ready),
    .break_detect (break_detect)
  );

  cmd_decode decode0 (
    .clock         (clock),
    .reset_n       (reset_n),
    .rx_data       (rx_data),
    .rx_valid      (rx_valid),
    .rx_ready      (rx_ready),
    .break_detect  (break_detect),
    .busy          (busy),
    .result_strobe (result_strobe),
    .exec_start    (exec_start),
    .exec_op       (exec_op),
    .exec_index    (exec_index),
    .exec_tag      (exec_tag),
    .exec_operand  (exec_operand)
  );

  cmd_execute execute0 (
    .clock         (clock),
    .reset_n       (reset_n),
    .exec_start    (exec_start),
    .exec_op       (exec_op),
    .exec_index    (exec_index),
    .exec_tag      (exec_tag),
    .exec_operand  (exec_operand),
    .result_strobe (result_strobe),
    .result_value  (result_value),
    .result_tag    (result_tag)
  );

  cmd_result result0 (
    .clock         (clock),
    .reset_n       (reset_n),
    .result_strobe (result_strobe),
    .result_value  (result_value),
    .result_tag    (result_tag),
    .busy          (busy),
    .resp_data     (resp_data),
    .resp_tag      (resp_tag),
    .resp_valid    (resp_valid),
    .resp_ready    (resp_ready)
  );

endmodule

`default_nettype wire

/* sim/uart_cmd_port_sva.sv */
// Response and break assertions
`timescale 1ns/1ps
`default_nettype none

module uart_cmd_port_sva (
  input logic                 clock,
  input logic                 reset_n,
  input uart_pkg::uart_char_t resp_data,
  input cmd_pkg::cmd_tag_t    resp_tag,
  input logic                 resp_valid,
  input logic                 resp_ready,
  input logic                 break_detect
);

  int failures = 0;

  // Held response stays put until taken
  hold_stable: assert property (
    @(posedge clock) disable iff (!reset_n)
    resp_valid && !resp_ready |=> resp_valid && $stable(resp_data) && $stable(resp_tag)
  ) else begin
    $error("held response changed before resp_ready");
    failures++;
  end

  reset_quiet: assert property (
    @(posedge clock) $rose(reset_n) |-> !resp_valid
  ) else begin
    $error("resp_valid high right after reset release");
    failures++;
  end

  no_resp_in_break: assert property (
    @(posedge clock) disable iff (!reset_n) break_detect |-> !$rose(resp_valid)
  ) else begin
    $error("resp_valid rose during a line break");
    failures++;
  end

endmodule

bind uart_cmd_port uart_cmd_port_sva sva0 (
  .clock        (clock),
  .reset_n      (reset_n),
  .resp_data    (resp_data),
  .resp_tag     (resp_tag),
  .resp_valid   (resp_valid),
  .resp_ready   (resp_ready),
  .break_detect (break_detect)
);

`default_nettype wire

/* sim/uart_cmd_port_tb.sv */
// Register access port testbench
`timescale 1ns/1ps
`default_nettype none

module uart_cmd_port_tb;
  import uart_pkg::*;
  import cmd_pkg::*;

  localparam int RESP_TIMEOUT = 64;
  localparam int BREAK_CLEAR_TIMEOUT = 16;

  logic        clock;
  logic        reset_n;
  logic        rx_in;
  logic        resp_ready;
  uart_char_t  resp_data;
  cmd_tag_t    resp_tag;
  logic        resp_valid;
  logic        break_detect;

  // Reference model of the register file
  uart_char_t  model_regs [NUM_REGS];
  cmd_header_t pending_hdr;
  logic        hdr_pending;
  logic        resp_pending;
  uart_char_t  model_value;
  cmd_tag_t    model_tag;
  int          holdoff;
  logic [31:0] rng_state;

  uart_cmd_port dut0 (
    .clock        (clock),
    .reset_n      (reset_n),
    .rx_in        (rx_in),
    .resp_data    (resp_data),
    .resp_tag     (resp_tag),
    .resp_valid   (resp_valid),
    .resp_ready   (resp_ready),
    .break_detect (break_detect)
  );

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("TEST RESULT: FAIL");
    $fatal(1, "simulation stopped at the first failure");
  endtask

  task automatic check_data(input string name, input uart_char_t actual,
                            input uart_char_t expected);
    if (actual !== expected) begin
      report_failure($sformatf("[ERROR] %s: got 0x%h, expected 0x%h", name, actual, expected));
    end
  endtask

  task automatic check_tag(input string name, input cmd_tag_t actual, input cmd_tag_t expected);
    if (actual !== expected) begin
      report_failure($sformatf("[ERROR] %s: got 0x%h, expected 0x%h", name, actual, expected));
    end
  endtask

  task automatic check_break(input string name, input logic actual, input logic expected);
    if (actual !== expected) begin
      report_failure($sformatf("[ERROR] %s: got 0x%h, expected 0x%h", name, actual, expected));
    end
  endtask

  function automatic logic [31:0] next_random();
    rng_state = rng_state * 32'd1103515245 + 32'd12345;
    return rng_state;
  endfunction

  task automatic apply_command(input cmd_header_t hdr, input uart_char_t operand);
    case (hdr.op)
      CMD_WRITE: model_regs[hdr.index] = operand;
      CMD_ADD:   model_regs[hdr.index] = model_regs[hdr.index] + operand;
      CMD_CLEAR: model_regs[hdr.index] = '0;
      default: begin
      end
    endcase
    model_value  = model_regs[hdr.index];
    model_tag    = hdr.tag;
    resp_pending = 1'b1;
  endtask

  // One line sample, then the break output must stay quiet
  task automatic drive_bit(input logic value);
    rx_in = value;
    @(negedge clock);
    check_break("break_detect", break_detect, 1'b0);
  endtask

  task automatic send_gap(input int samples);
    for (int i = 0; i < samples; i++) begin
      drive_bit(1'b1);
    end
  endtask

  task automatic send_frame(input uart_char_t value, input logic stop);
    if (resp_valid) begin
      report_failure("a response appeared that no command asked for");
    end
    drive_bit(1'b0);
    for (int i = 0; i < DATA_BITS; i++) begin
      drive_bit(value[i]);
    end
    drive_bit(stop);
    drive_bit(1'b1);
    // Bytes with a low stop bit never reach the decoder
    if (stop && hdr_pending) begin
      apply_command(pending_hdr, value);
      hdr_pending = 1'b0;
    end else if (stop) begin
      pending_hdr = value;
      if (pending_hdr.op == CMD_WRITE || pending_hdr.op == CMD_ADD) begin
        hdr_pending = 1'b1;
      end else begin
        apply_command(pending_hdr, '0);
      end
    end
  endtask

  task automatic send_break(input int low_samples);
    int count;
    if (low_samples < BREAK_THRESHOLD) begin
      report_failure($sformatf("testdata break of %0d samples is below the threshold",
                               low_samples));
    end
    count = 0;
    rx_in = 1'b0;
    while (!break_detect && count < low_samples) begin
      @(negedge clock);
      count++;
    end
    if (!break_detect) begin
      report_failure($sformatf("break_detect never rose in %0d low samples", low_samples));
    end
    while (count < low_samples) begin
      @(negedge clock);
      count++;
    end
    hdr_pending = 1'b0;
    rx_in = 1'b1;
    count = 0;
    while (break_detect && count < BREAK_CLEAR_TIMEOUT) begin
      @(negedge clock);
      count++;
    end
    if (break_detect) begin
      report_failure("break_detect never fell after the line returned high");
    end
  endtask

  task automatic expect_response(input uart_char_t file_value, input cmd_tag_t file_tag);
    int count;
    if (!resp_pending) begin
      report_failure("testdata expects a response but no command was completed");
    end
    check_data("testdata value", file_value, model_value);
    check_tag("testdata tag", file_tag, model_tag);
    count = 0;
    while (!resp_valid && count < RESP_TIMEOUT) begin
      @(negedge clock);
      count++;
    end
    if (!resp_valid) begin
      report_failure($sformatf("no response on resp_valid within %0d cycles", RESP_TIMEOUT));
    end
    check_data("resp_data", resp_data, model_value);
    check_tag("resp_tag", resp_tag, model_tag);
    for (int i = 0; i < holdoff; i++) begin
      @(negedge clock);
      if (!resp_valid) begin
        report_failure("resp_valid dropped while resp_ready was low");
      end
      check_data("resp_data", resp_data, model_value);
      check_tag("resp_tag", resp_tag, model_tag);
    end
    resp_ready = 1'b1;
    @(negedge clock);
    resp_ready = 1'b0;
    if (resp_valid) begin
      report_failure("resp_valid stayed high after the handshake");
    end
    resp_pending = 1'b0;
    holdoff = 0;
  endtask

  initial begin
    string       line;
    int          fd;
    int          fields;
    logic [7:0]  code;
    logic [31:0] arg0;
    logic [31:0] arg1;

    rx_in        = 1'b1;
    resp_ready   = 1'b0;
    reset_n      = 1'b0;
    hdr_pending  = 1'b0;
    resp_pending = 1'b0;
    pending_hdr  = '0;
    model_value  = '0;
    model_tag    = '0;
    holdoff      = 0;
    rng_state    = 32'h5c56;
    for (int i = 0; i < NUM_REGS; i++) begin
      model_regs[i] = '0;
    end

    repeat (8) @(negedge clock);
    reset_n = 1'b1;
    send_gap(4);

    fd = $fopen("sim/uart_cmd_port_testdata.txt", "r");
    if (fd == 0) begin
      report_failure("cannot open sim/uart_cmd_port_testdata.txt");
    end
    while (!$feof(fd)) begin
      if ($fgets(line, fd) != 0 && $sscanf(line, "%c", code) == 1) begin
        case (code)
          "F", "E": begin
            fields = $sscanf(line, "%c %h %h", code, arg0, arg1);
            if (fields != 3) begin
              report_failure($sformatf("malformed testdata line: %s", line));
            end
            if (code == "F") begin
              send_frame(arg0[7:0], arg1[0]);
            end else begin
              expect_response(arg0[7:0], arg1[2:0]);
            end
          end
          "G": begin
            fields = $sscanf(line, "%c %d", code, arg0);
            send_gap(arg0);
          end
          "B": begin
            fields = $sscanf(line, "%c %d", code, arg0);
            send_break(arg0);
          end
          "H": begin
            // No count given, so pick one from 1 to 8
            fields = $sscanf(line, "%c %d", code, arg0);
            holdoff = (fields == 2) ? arg0 : 1 + (next_random() >> 16) % 8;
          end
          "#", "\n", "\r", " ": begin
          end
          default: report_failure($sformatf("unknown testdata line: %s", line));
        endcase
      end
    end
    $fclose(fd);

    send_gap(8);
    if (resp_valid || resp_pending) begin
      report_failure("a command finished without a matching response check");
    end
    if (dut0.sva0.failures == 0) begin
      $display("TEST RESULT: PASS");
      $finish;
    end else begin
      report_failure($sformatf("%0d assertion failures", dut0.sva0.failures));
    end
  end

endmodule

`default_nettype wire

/* sim/uart_cmd_port_testdata.txt */
# F byte stop | G idle samples | B low samples | H resp_ready hold-off, random if blank
# E expected value and tag; bytes and tags in hex, counts in decimal
F 5D 1
F A5 1
E A5 5
F 1A 1
E A5 2
F 71 1
F F0 1
E F0 1
F B4 1
F 25 1
E 15 4
F DF 1
E 00 7
F 18 1
E 00 0
H 6
F 33 1
E 15 3
H
F B6 1
F 01 1
E 16 6
F 4A 1
G 3
B 16
G 4
F 4B 1
F 3C 1
E 3C 3
F 80 0
G 4
F 40 0
G 4
F 09 1
E 3C 1
B 24
G 2

/* compile.f */
common/uart_pkg.sv
common/cmd_pkg.sv
verilog/uart_rx/uart_break_detect.sv
verilog/cmd_decode.sv
verilog/cmd_execute.sv
verilog/cmd_result.sv
verilog/uart_cmd_port.sv
sim/uart_cmd_port_sva.sv
sim/uart_cmd_port_tb.sv
